// File: bench/ifetch_checker.sv
module ifetch_checker (
    input logic              clk,
    input logic              rst,
    input logic              bmem_read_i,
    input logic              bmem_ready_i,
    input logic              inst_valid_i,
    input logic              inst_ready_i,
    input ifetch_pkg::addr_t inst_pc_i,
    input ifetch_pkg::inst_t inst_i,
    input logic              redirect_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // summed into the testbench total

    read_one_cycle: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |=> !bmem_read_i)
        else begin
            $error("bmem_read high for two cycles in a row");
            fail_count = fail_count + 1;
        end

    read_when_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_ready_i)
        else begin
            $error("bmem_read issued while memory not ready");
            fail_count = fail_count + 1;
        end

    // stalled head entry must not move
    hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
        (inst_valid_i && !inst_ready_i && !redirect_i) |=>
            ($stable(inst_pc_i) && $stable(inst_i)))
        else begin
            $error("queue output changed while stalled");
            fail_count = fail_count + 1;
        end

endmodule

// File: bench/ifetch_tb.sv
`include "ifetch_defines.svh"

module ifetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam bit [31:0] SEED = 32'h40d5_4932;
    localparam int N_SEQ        = 200;
    localparam int N_STALL      = 300;
    localparam int N_REDIR      = 40;
    localparam int REDIR_INSTS  = 16;   // rough yield per redirect
    localparam int LOOP_PASSES  = 6;
    localparam ifetch_pkg::addr_t LOOP_BASE  = `IFETCH_RESET_PC + 32'h4000;
    localparam ifetch_pkg::addr_t LOOP_BYTES = 32'd256;
    localparam ifetch_pkg::addr_t LOOP_END   = LOOP_BASE + LOOP_BYTES - 32'd4;
    localparam int LOOP_WORDS   = LOOP_BYTES / 4;
    localparam int EXPECTED     = N_SEQ + N_STALL + N_REDIR * REDIR_INSTS +
                                  LOOP_PASSES * LOOP_WORDS;
    localparam int WATCHDOG_CYCLES = 400 * EXPECTED + 2000;

    logic              clk, rst;
    ifetch_pkg::addr_t bmem_addr_o, bmem_raddr_i;
    logic              bmem_read_o, bmem_ready_i, bmem_rvalid_i;
    ifetch_pkg::beat_t bmem_rdata_i;
    logic              inst_valid_o, inst_ready_i;
    ifetch_pkg::addr_t inst_pc_o;
    ifetch_pkg::inst_t inst_o;
    logic              redirect_i;
    ifetch_pkg::addr_t redirect_pc_i;

    ifetch_pkg::addr_t exp_pc = `IFETCH_RESET_PC;
    int                acc_count = 0;
    int                errors = 0;
    bit                seen_run = 1'b0;
    bit                random_ready;
    bit                loop_check_on;

    ifetch_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .inst_valid_o  (inst_valid_o),
        .inst_pc_o     (inst_pc_o),
        .inst_o        (inst_o),
        .inst_ready_i  (inst_ready_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i)
    );

    bind ifetch_top ifetch_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .bmem_read_i  (bmem_read_o),
        .bmem_ready_i (bmem_ready_i),
        .inst_valid_i (inst_valid_o),
        .inst_ready_i (inst_ready_i),
        .inst_pc_i    (inst_pc_o),
        .inst_i       (inst_o),
        .redirect_i   (redirect_i)
    );

    // address bits below, their inverse above
    function automatic ifetch_pkg::inst_t mem_word(input ifetch_pkg::addr_t a);
        return {~a[15:0], a[15:0]};
    endfunction

    function automatic bit in_loop(input ifetch_pkg::addr_t a);
        return (a >= LOOP_BASE) && (a < LOOP_BASE + LOOP_BYTES);
    endfunction

    function automatic bit loop_end_accepted();
        return inst_valid_o && inst_ready_i && !redirect_i && (inst_pc_o == LOOP_END);
    endfunction

    task automatic check_pc(input ifetch_pkg::addr_t got, input ifetch_pkg::addr_t exp);
        if (got !== exp) begin
            $display("error inst_pc_o: got %h expected %h at %0t", got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_inst(input ifetch_pkg::inst_t got, input ifetch_pkg::inst_t exp,
                              input ifetch_pkg::addr_t pc);
        if (got !== exp) begin
            $display("error inst_o: got %h expected %h for pc %h", got, exp, pc);
            errors++;
        end
    endtask

    task automatic require_idle(input string when);
        if (inst_valid_o !== 1'b0) begin
            $display("inst_valid_o was not low %s", when);
            errors++;
        end
        if (bmem_read_o !== 1'b0) begin
            $display("bmem_read_o was not low %s", when);
            errors++;
        end
    endtask

    task automatic send_redirect(input ifetch_pkg::addr_t target);
        redirect_pc_i <= target;
        redirect_i    <= 1'b1;
        @(posedge clk);
        redirect_i    <= 1'b0;
    endtask

    // lowest beat of the line goes out first
    task automatic serve_burst(input ifetch_pkg::addr_t base);
        int delay;
        delay = 2 + int'($urandom % 8);
        bmem_ready_i <= 1'b0;
        bmem_raddr_i <= base;
        repeat (delay - 1) @(posedge clk);
        for (int k = 0; k < `IFETCH_LINE_BEATS; k++) begin
            bmem_rdata_i  <= {mem_word(base + 32'(8 * k + 4)), mem_word(base + 32'(8 * k))};
            bmem_rvalid_i <= 1'b1;
            @(posedge clk);
        end
        bmem_rvalid_i <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        bmem_ready_i  = 1'b1;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        bmem_rvalid_i = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && bmem_read_o) begin
                serve_burst(bmem_addr_o);
            end else begin
                bmem_ready_i <= ($urandom % 4) != 0;   // busy now and then
            end
        end
    end

    initial begin
        int stretch;
        stretch = 0;
        inst_ready_i = 1'b1;
        forever begin
            @(posedge clk);
            if (!random_ready) begin
                inst_ready_i <= 1'b1;
            end else if (stretch == 0) begin
                inst_ready_i <= ($urandom % 2) != 0;
                stretch = 1 + int'($urandom % 128);   // long enough to fill the queue
            end else begin
                stretch--;
            end
        end
    end

    // compare every accepted output against the model
    always @(negedge clk) begin
        if (rst) begin
            require_idle("during reset");
        end else begin
            if (!seen_run) begin
                require_idle("right after reset");
                seen_run = 1'b1;
            end
            if (loop_check_on && bmem_read_o && in_loop(bmem_addr_o)) begin
                $display("loop line %h was fetched from memory after the first pass",
                         bmem_addr_o);
                errors++;
            end
            if (redirect_i) begin
                exp_pc = redirect_pc_i;   // queue flushed at this edge
            end else if (inst_valid_o && inst_ready_i) begin
                check_pc(inst_pc_o, exp_pc);
                check_inst(inst_o, mem_word(exp_pc), exp_pc);
                exp_pc = exp_pc + 32'd4;
                acc_count++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: fetch stalled for good, %0d instructions checked", acc_count);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int gap;
        int base_count;
        int total;
        ifetch_pkg::addr_t target;
        void'($urandom(SEED));
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        random_ready  = 1'b0;
        loop_check_on = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        wait (acc_count >= N_SEQ);
        random_ready = 1'b1;   // back-pressure fills the queue
        wait (acc_count >= N_SEQ + N_STALL);

        for (int i = 0; i < N_REDIR; i++) begin
            gap = 1 + int'($urandom % 30);
            repeat (gap) @(posedge clk);
            target = `IFETCH_RESET_PC + (($urandom % 32'h2000) & 32'hffff_fffc);
            base_count = acc_count;
            send_redirect(target);
            wait (acc_count > base_count);
        end

        random_ready = 1'b0;
        @(posedge clk);
        send_redirect(LOOP_BASE);
        for (int pass = 0; pass < LOOP_PASSES; pass++) begin
            while (!loop_end_accepted()) @(posedge clk);
            loop_check_on = 1'b1;   // every loop line is cached now
            send_redirect(LOOP_BASE);
        end
        repeat (40) @(posedge clk);

        total = errors + u_dut.u_checker.fail_count;
        $display("summary: %0d errors, %0d assertion failures, %0d instructions checked",
                 errors, u_dut.u_checker.fail_count, acc_count);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: hdl/fetch_unit.sv
`include "ifetch_defines.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              rst,

    input  logic              resp_valid_i,
    input  ifetch_pkg::inst_t resp_inst_i,
    input  logic              full_i,
    input  logic              redirect_i,
    input  ifetch_pkg::addr_t redirect_pc_i,

    output logic              req_valid_o,
    output ifetch_pkg::addr_t req_addr_o,
    output logic              push_o,
    output ifetch_pkg::addr_t push_pc_o,
    output ifetch_pkg::inst_t push_inst_o
);

    ifetch_pkg::fetch_state_t state, state_next;
    ifetch_pkg::addr_t        pc;
    logic                     drop_q;   // outstanding response is stale
    logic                     issue;

    assign issue       = (state == ifetch_pkg::RUN) && !full_i;
    assign req_valid_o = issue;
    assign req_addr_o  = pc;

    // a response coinciding with a redirect belongs to the old path
    assign push_o      = (state == ifetch_pkg::WAIT_RESP) && resp_valid_i &&
                         !drop_q && !redirect_i;
    assign push_pc_o   = pc;   // pc only moves once the response is in
    assign push_inst_o = resp_inst_i;

    always_comb begin
        state_next = state;
        case (state)
            ifetch_pkg::RUN: begin
                state_next = full_i ? ifetch_pkg::STALL : ifetch_pkg::WAIT_RESP;
            end
            ifetch_pkg::WAIT_RESP: begin
                if (resp_valid_i) begin
                    state_next = ifetch_pkg::RUN;
                end
            end
            ifetch_pkg::STALL: begin
                if (!full_i) begin
                    state_next = ifetch_pkg::RUN;
                end
            end
            default: begin
                state_next = ifetch_pkg::STALL;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ifetch_pkg::STALL;   // first request one cycle after reset
            pc     <= `IFETCH_RESET_PC;
            drop_q <= 1'b0;
        end else begin
            state <= state_next;

            if (redirect_i) begin
                pc <= redirect_pc_i;
            end else if (push_o) begin
                pc <= pc + 32'd4;
            end

            // request in flight across a redirect, its answer gets discarded
            if (redirect_i &&
                (issue || (state == ifetch_pkg::WAIT_RESP && !resp_valid_i))) begin
                drop_q <= 1'b1;
            end else if (resp_valid_i) begin
                drop_q <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/icache.sv
`include "ifetch_defines.svh"

module icache (
    input  logic              clk,
    input  logic              rst,

    input  logic              req_valid_i,
    input  ifetch_pkg::addr_t req_addr_i,
    input  logic              line_valid_i,
    input  ifetch_pkg::line_t line_data_i,
    input  logic              bmem_ready_i,

    output logic              resp_valid_o,
    output ifetch_pkg::inst_t resp_inst_o,
    output ifetch_pkg::addr_t bmem_addr_o,
    output logic              bmem_read_o
);

    localparam int ADDR_BITS   = $bits(ifetch_pkg::addr_t);
    localparam int OFFSET_BITS = $clog2(`IFETCH_LINE_BEATS * 8);
    localparam int INDEX_BITS  = $clog2(`IFETCH_NUM_SETS);
    localparam int TAG_BITS    = ADDR_BITS - OFFSET_BITS - INDEX_BITS;
    localparam int WORD_BITS   = OFFSET_BITS - 2;

    ifetch_pkg::icache_state_t state, state_next;
    ifetch_pkg::addr_t         addr_q;

    ifetch_pkg::line_t         data_mem [`IFETCH_NUM_SETS];
    logic [TAG_BITS-1:0]       tag_mem  [`IFETCH_NUM_SETS];
    logic [`IFETCH_NUM_SETS-1:0] valid_q;

    logic [TAG_BITS-1:0]       tag;
    logic [INDEX_BITS-1:0]     index;
    logic [WORD_BITS-1:0]      word_sel;
    ifetch_pkg::line_t         sel_line;
    logic                      hit;

    // address split
    assign tag      = addr_q[ADDR_BITS-1 -: TAG_BITS];
    assign index    = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign word_sel = addr_q[2 +: WORD_BITS];

    assign sel_line    = data_mem[index];
    assign hit         = valid_q[index] && (tag_mem[index] == tag);
    assign resp_inst_o = sel_line[word_sel * 32 +: 32];

    assign bmem_addr_o = {addr_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    always_comb begin
        state_next   = state;
        resp_valid_o = 1'b0;
        bmem_read_o  = 1'b0;
        case (state)
            ifetch_pkg::IDLE: begin
                if (req_valid_i) begin
                    state_next = ifetch_pkg::LOOKUP;
                end
            end
            ifetch_pkg::LOOKUP: begin
                if (hit) begin
                    resp_valid_o = 1'b1;
                    state_next   = ifetch_pkg::IDLE;
                end else begin
                    state_next = ifetch_pkg::MISS_REQ;
                end
            end
            ifetch_pkg::MISS_REQ: begin
                // single pulse, only while memory can take it
                if (bmem_ready_i) begin
                    bmem_read_o = 1'b1;
                    state_next  = ifetch_pkg::MISS_WAIT;
                end
            end
            ifetch_pkg::MISS_WAIT: begin
                if (line_valid_i) begin
                    state_next = ifetch_pkg::FILL;
                end
            end
            ifetch_pkg::FILL: begin
                resp_valid_o = 1'b1;   // line now in the array
                state_next   = ifetch_pkg::IDLE;
            end
            default: begin
                state_next = ifetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ifetch_pkg::IDLE;
            valid_q <= '0;
        end else begin
            state <= state_next;
            if (state == ifetch_pkg::MISS_WAIT && line_valid_i) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ifetch_pkg::IDLE && req_valid_i) begin
            addr_q <= req_addr_i;
        end
        if (state == ifetch_pkg::MISS_WAIT && line_valid_i) begin
            data_mem[index] <= line_data_i;
            tag_mem[index]  <= tag;
        end
    end

endmodule

// File: hdl/ifetch_defines.svh
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// first fetch address out of reset
`define IFETCH_RESET_PC 32'h1eceb000

// instruction queue entries
`define IFETCH_IQ_DEPTH 16

// direct-mapped icache lines
`define IFETCH_NUM_SETS 16

// 64-bit burst beats per 256-bit line
`define IFETCH_LINE_BEATS 4

`endif

// File: hdl/ifetch_pkg.sv
`include "ifetch_defines.svh"

package ifetch_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] inst_t;
    typedef logic [63:0] beat_t;   // one burst beat

    // whole cache line, sized by the burst
    typedef logic [`IFETCH_LINE_BEATS*64-1:0] line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        FILL
    } icache_state_t;

    typedef enum logic [1:0] {
        RUN,
        WAIT_RESP,
        STALL
    } fetch_state_t;

endpackage

// File: hdl/ifetch_top.sv
module ifetch_top (
    input  logic              clk,
    input  logic              rst,

    // burst memory port
    output ifetch_pkg::addr_t bmem_addr_o,
    output logic              bmem_read_o,
    input  logic              bmem_ready_i,
    input  ifetch_pkg::addr_t bmem_raddr_i,   // unused, port parity with the core
    input  ifetch_pkg::beat_t bmem_rdata_i,
    input  logic              bmem_rvalid_i,

    // to dispatch
    output logic              inst_valid_o,
    output ifetch_pkg::addr_t inst_pc_o,
    output ifetch_pkg::inst_t inst_o,
    input  logic              inst_ready_i,

    input  logic              redirect_i,
    input  ifetch_pkg::addr_t redirect_pc_i
);

    logic              req_valid;
    ifetch_pkg::addr_t req_addr;
    logic              resp_valid;
    ifetch_pkg::inst_t resp_inst;

    logic              push;
    ifetch_pkg::addr_t push_pc;
    ifetch_pkg::inst_t push_inst;
    logic              full;

    logic              line_valid;
    ifetch_pkg::line_t line_data;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst           (rst),
        .resp_valid_i  (resp_valid),
        .resp_inst_i   (resp_inst),
        .full_i        (full),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .req_valid_o   (req_valid),
        .req_addr_o    (req_addr),
        .push_o        (push),
        .push_pc_o     (push_pc),
        .push_inst_o   (push_inst)
    );

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .line_valid_i (line_valid),
        .line_data_i  (line_data),
        .bmem_ready_i (bmem_ready_i),
        .resp_valid_o (resp_valid),
        .resp_inst_o  (resp_inst),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o)
    );

    line_adapter u_adapter (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_valid_o  (line_valid),
        .line_data_o   (line_data)
    );

    inst_queue u_iq (
        .clk         (clk),
        .rst         (rst),
        .push_i      (push),
        .push_pc_i   (push_pc),
        .push_inst_i (push_inst),
        .pop_ready_i (inst_ready_i),
        .flush_i     (redirect_i),   // wrong-path entries go on redirect
        .full_o      (full),
        .valid_o     (inst_valid_o),
        .pc_o        (inst_pc_o),
        .inst_o      (inst_o)
    );

endmodule

// File: hdl/inst_queue.sv
`include "ifetch_defines.svh"

module inst_queue (
    input  logic              clk,
    input  logic              rst,

    input  logic              push_i,
    input  ifetch_pkg::addr_t push_pc_i,
    input  ifetch_pkg::inst_t push_inst_i,
    input  logic              pop_ready_i,
    input  logic              flush_i,

    output logic              full_o,
    output logic              valid_o,
    output ifetch_pkg::addr_t pc_o,
    output ifetch_pkg::inst_t inst_o
);

    localparam int PTR_W = $clog2(`IFETCH_IQ_DEPTH);
    localparam int CNT_W = $clog2(`IFETCH_IQ_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`IFETCH_IQ_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH    = CNT_W'(`IFETCH_IQ_DEPTH);

    // pc and word share one entry
    ifetch_pkg::addr_t pc_mem   [`IFETCH_IQ_DEPTH];
    ifetch_pkg::inst_t inst_mem [`IFETCH_IQ_DEPTH];

    logic [PTR_W-1:0] head, tail;
    logic [CNT_W-1:0] count;
    logic             do_push, do_pop;

    assign valid_o = (count != '0);
    assign full_o  = (count == DEPTH);
    assign pc_o    = pc_mem[head];
    assign inst_o  = inst_mem[head];

    assign do_pop  = valid_o && pop_ready_i;
    assign do_push = push_i && (!full_o || do_pop);   // full but draining is ok

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= (tail == LAST_IDX) ? '0 : tail + 1'b1;
            end
            if (do_pop) begin
                head <= (head == LAST_IDX) ? '0 : head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[tail]   <= push_pc_i;
            inst_mem[tail] <= push_inst_i;
        end
    end

endmodule

// File: hdl/line_adapter.sv
`include "ifetch_defines.svh"

module line_adapter (
    input  logic              clk,
    input  logic              rst,

    input  ifetch_pkg::beat_t bmem_rdata_i,
    input  logic              bmem_rvalid_i,

    output logic              line_valid_o,
    output ifetch_pkg::line_t line_data_o
);

    localparam int LINE_BITS = $bits(ifetch_pkg::line_t);
    localparam int BEAT_BITS = $bits(ifetch_pkg::beat_t);
    localparam int CNT_W     = $clog2(`IFETCH_LINE_BEATS);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`IFETCH_LINE_BEATS - 1);

    logic [CNT_W-1:0]  beat_cnt;
    ifetch_pkg::line_t line_q;
    logic              line_valid_q;

    assign line_valid_o = line_valid_q;
    assign line_data_o  = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= bmem_rvalid_i && (beat_cnt == LAST_BEAT);
            if (bmem_rvalid_i) begin
                beat_cnt <= (beat_cnt == LAST_BEAT) ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // lowest beat arrives first and ends up at the bottom
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

endmodule

// File: ifetch_top.f
+incdir+hdl
hdl/ifetch_pkg.sv
hdl/fetch_unit.sv
hdl/icache.sv
hdl/line_adapter.sv
hdl/inst_queue.sv
hdl/ifetch_top.sv
bench/ifetch_checker.sv
bench/ifetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fetch front end testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module ifetch_tb -Mdir obj_dir -f ifetch_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vifetch_tb +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" <<< "$sim_out"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
